// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_spi_sdram
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f files.f --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== bench/sdram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_model
  import spi_sdram_pkg::*;
(
  input  logic        clk,
  input  logic        cke,
  input  logic        csn,
  input  logic        rasn,
  input  logic        casn,
  input  logic        wen,
  input  logic [12:0] a,
  input  logic [1:0]  ba,
  input  logic [1:0]  dqm,      // byte masks, no partial words here
  inout  wire  [15:0] dq,
  output int          errors,
  output int          refreshes,
  output logic        pre_seen,
  output logic [12:0] mode_val
);

  localparam int REF_MARGIN = 40;  // slack for an access in flight when refresh falls due

  sdram_cmd_t  cmd;
  logic [15:0] mem [logic [22:0]];  // sparse, unwritten words read as zero
  logic        bank_open [4];
  logic [12:0] open_row [4];
  longint      pre_at [4];          // cycle of the last precharge per bank
  longint      cycle;
  longint      last_ref;
  logic        rd_pend;
  logic        dq_oe;
  logic [15:0] dq_q;
  logic [22:0] key;

  assign cmd = sdram_cmd_t'({csn, rasn, casn, wen});
  assign dq  = dq_oe ? dq_q : 16'hzzzz;

  initial
  begin
    errors    = 0;
    refreshes = 0;
    pre_seen  = 1'b0;
    mode_val  = '0;
    cycle     = 0;
    last_ref  = 0;
    rd_pend   = 1'b0;
    dq_oe     = 1'b0;
    dq_q      = '0;
    for (int b = 0; b < 4; b++)
    begin
      bank_open[b] = 1'b0;
      open_row[b]  = '0;
      pre_at[b]    = -100;
    end
  end

  always @(posedge clk)
  begin
    cycle++;
    dq_oe   <= rd_pend;  // cl2: data out on the second edge after READ
    rd_pend <= 1'b0;
    assert (dqm === 2'b00)
    else
    begin
      errors++;
      $display("sdram_model: %0t dqm is %b instead of zero", $time, dqm);
    end
    if (cke !== 1'b1)
    begin
      assert ({csn, rasn, casn, wen} === 4'b0111)
      else
      begin
        errors++;
        $display("sdram_model: %0t command %b issued while cke low", $time,
                 {csn, rasn, casn, wen});
      end
    end
    else
    begin
      case (cmd)
        ACTIVE:
        begin
          assert (cycle - pre_at[ba] >= T_RP)
          else
          begin
            errors++;
            $display("sdram_model: %0t ACTIVE on bank %0d too soon after precharge",
                     $time, ba);
          end
          bank_open[ba] = 1'b1;
          open_row[ba]  = a;
        end
        READ, WRITE:
        begin
          assert (bank_open[ba])
          else
          begin
            errors++;
            $display("sdram_model: %0t access to bank %0d which is not open", $time, ba);
          end
          key = {open_row[ba][11:0], ba, a[8:0]};
          if (cmd == WRITE)
            mem[key] = dq;
          else
          begin
            dq_q    <= mem.exists(key) ? mem[key] : 16'h0000;
            rd_pend <= 1'b1;
          end
          if (a[10])  // auto precharge
          begin
            bank_open[ba] = 1'b0;
            pre_at[ba]    = cycle;
          end
        end
        PRECHARGE:
        begin
          pre_seen = 1'b1;
          for (int b = 0; b < 4; b++)
            if (a[10] || b == ba)
            begin
              bank_open[b] = 1'b0;
              pre_at[b]    = cycle;
            end
        end
        REFRESH:
        begin
          assert (last_ref == 0 || cycle - last_ref <= REFRESH_INTERVAL + REF_MARGIN)
          else
          begin
            errors++;
            $display("sdram_model: %0t refresh gap of %0d cycles too long", $time,
                     cycle - last_ref);
          end
          refreshes++;
          last_ref = cycle;
        end
        LOAD_MODE:
        begin
          mode_val = a;
          last_ref = cycle;  // refresh gaps count from the end of init
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== bench/tb_spi_sdram.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_spi_sdram;
  import spi_sdram_pkg::*;

  typedef logic [7:0] byte_q_t [$];

  localparam int HALF_SCLK     = 10;     // clk per sclk half period
  localparam int READY_TIMEOUT = 30000;

  // mode register {reserved, write burst, op mode, cl, burst type, burst length}
  localparam logic [12:0] EXP_MODE = {3'b000, 1'b0, 2'b00, 3'd2, 1'b0, 3'b000};

  logic        clk;
  logic        arst_n;
  logic        spi_csn;
  logic        spi_sclk;
  logic        spi_mosi;
  logic        spi_miso;
  logic        sdram_cke;
  logic        sdram_csn;
  logic        sdram_rasn;
  logic        sdram_casn;
  logic        sdram_wen;
  logic [12:0] sdram_a;
  logic [1:0]  sdram_ba;
  logic [1:0]  sdram_dqm;
  wire  [15:0] sdram_dq;
  logic [7:0]  ctrl_reg;
  logic        sdram_ready;
  int          model_errors;
  int          refreshes;
  logic        pre_seen;
  logic [12:0] mode_val;

  int          value_errors = 0;
  logic [31:0] lfsr_state = 32'h19f8;
  logic [7:0]  ref_mem [logic [31:0]];  // byte-wise scoreboard
  logic [7:0]  stage_hi;                // last even byte staged
  logic [7:0]  exp_ctrl = 8'd0;

  spi_sdram_top i_spi_sdram_top (
    .clk         (clk),
    .arst_n      (arst_n),
    .spi_csn     (spi_csn),
    .spi_sclk    (spi_sclk),
    .spi_mosi    (spi_mosi),
    .spi_miso    (spi_miso),
    .sdram_cke   (sdram_cke),
    .sdram_csn   (sdram_csn),
    .sdram_rasn  (sdram_rasn),
    .sdram_casn  (sdram_casn),
    .sdram_wen   (sdram_wen),
    .sdram_a     (sdram_a),
    .sdram_ba    (sdram_ba),
    .sdram_dqm   (sdram_dqm),
    .sdram_dq    (sdram_dq),
    .ctrl_reg    (ctrl_reg),
    .sdram_ready (sdram_ready)
  );

  sdram_model i_model (
    .clk       (clk),
    .cke       (sdram_cke),
    .csn       (sdram_csn),
    .rasn      (sdram_rasn),
    .casn      (sdram_casn),
    .wen       (sdram_wen),
    .a         (sdram_a),
    .ba        (sdram_ba),
    .dqm       (sdram_dqm),
    .dq        (sdram_dq),
    .errors    (model_errors),
    .refreshes (refreshes),
    .pre_seen  (pre_seen),
    .mode_val  (mode_val)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] r);
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);  // one step per bit
      r = {r[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      value_errors++;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // scoreboard side of a byte write, same packing as the bridge
  task automatic model_write(input logic [31:0] a, input logic [7:0] d);
    if (a[31:24] == REGION_SDRAM)
    begin
      if (!a[0])
        stage_hi = d;
      else
      begin
        ref_mem[{a[31:1], 1'b0}] = stage_hi;  // commit on the odd byte
        ref_mem[a] = d;
      end
    end
    else if (a[31:24] == REGION_CTRL)
      exp_ctrl = d;
  endtask

  function automatic logic [7:0] expected_byte(input logic [31:0] a);
    if (a[31:24] == REGION_SDRAM)
      return ref_mem.exists(a) ? ref_mem[a] : 8'h00;
    else if (a[31:24] == REGION_CTRL)
      return exp_ctrl;
    return 8'h00;  // unmapped
  endfunction

  // mode 0: mosi set while sclk low, miso sampled just before the rise
  task automatic xfer_byte(input logic [7:0] tx, output logic [7:0] rx);
    @(posedge clk);
    #1;
    for (int i = 7; i >= 0; i--)
    begin
      spi_mosi = tx[i];
      repeat (HALF_SCLK) @(posedge clk);
      #1;
      rx[i]    = spi_miso;
      spi_sclk = 1'b1;
      repeat (HALF_SCLK) @(posedge clk);
      #1;
      spi_sclk = 1'b0;
    end
  endtask

  task automatic frame_start(input logic [7:0] cmd, input logic [31:0] addr);
    logic [7:0] rx;
    @(posedge clk);
    #1;
    spi_csn = 1'b0;
    repeat (4) @(posedge clk);
    xfer_byte(cmd, rx);
    for (int i = 3; i >= 0; i--)
      xfer_byte(addr[8*i +: 8], rx);  // msb first
  endtask

  task automatic frame_end();
    repeat (4) @(posedge clk);
    #1;
    spi_csn  = 1'b1;
    spi_mosi = 1'b0;
    repeat (20) @(posedge clk);
  endtask

  task automatic spi_write(input logic [31:0] addr, input byte_q_t data);
    logic [7:0] rx;
    frame_start(SPI_CMD_WRITE, addr);
    foreach (data[i])
    begin
      xfer_byte(data[i], rx);
      model_write(addr + i, data[i]);
    end
    frame_end();
  endtask

  task automatic spi_read(input logic [31:0] addr, input int n);
    logic [7:0] rx;
    frame_start(SPI_CMD_READ, addr);
    xfer_byte(8'h00, rx);  // dummy byte, prefetch time
    for (int i = 0; i < n; i++)
    begin
      xfer_byte(8'h00, rx);
      check_val($sformatf("spi_miso byte @%h", addr + i), expected_byte(addr + i), rx);
    end
    frame_end();
  endtask

  task automatic rand_data(input int n, output byte_q_t q);
    logic [31:0] r;
    q = {};
    for (int i = 0; i < n; i++)
    begin
      rand_bits(8, r);
      q.push_back(r[7:0]);
    end
  endtask

  initial
  begin
    logic [31:0] r;
    logic [31:0] addr;
    byte_q_t     q;
    int          n;
    int          ref_start;
    clk      = 1'b0;
    arst_n   = 1'b1;
    spi_csn  = 1'b1;
    spi_sclk = 1'b0;
    spi_mosi = 1'b0;
    #1;
    arst_n = 1'b0;  // falling edge resets the dut ahead of the first clk edge
    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_val("sdram_ready", 0, sdram_ready);
    check_val("ctrl_reg", 0, ctrl_reg);
    check_val("sdram_cke", 0, sdram_cke);
    check_val("spi_miso", 0, spi_miso);

    // init sequence, cke low phase is watched by the model
    for (int i = 0; i < READY_TIMEOUT && sdram_ready !== 1'b1; i++)
      @(posedge clk);
    if (sdram_ready !== 1'b1)
    begin
      $display("timeout: sdram_ready still low after %0d cycles", READY_TIMEOUT);
      $display("TESTBENCH FAILED");
      $finish;
    end
    else
    begin
      check_val("init precharge seen", 1, pre_seen);
      check_val("init refresh count", 2, refreshes);
      check_val("mode register", EXP_MODE, mode_val);

      // even aligned write then read back
      rand_bits(20, r);
      addr = {12'h000, r[19:1], 1'b0};
      rand_data(6, q);
      spi_write(addr, q);
      spi_read(addr, 6);

      // odd start, trailing even byte stays staged only
      addr = addr + 32'h100 + 1;
      rand_data(4, q);
      spi_write(addr, q);
      spi_read(addr - 1, 6);

      // control register and an unmapped region
      rand_data(1, q);
      spi_write(32'hFF00_0000, q);
      check_val("ctrl_reg", exp_ctrl, ctrl_reg);
      spi_read(32'hFF00_0010, 2);
      rand_data(2, q);
      spi_write(32'h0100_0040, q);
      check_val("ctrl_reg", exp_ctrl, ctrl_reg);
      spi_read(32'h0100_0040, 2);
      spi_read(32'h0000_0040, 2);  // sdram untouched

      // random traffic over many refresh intervals
      ref_start = refreshes;
      for (int k = 0; k < 30; k++)
      begin
        rand_bits(14, r);
        addr = {18'h0, r[13:0]};
        rand_bits(2, r);
        n = r + 1;
        rand_bits(1, r);
        if (r[0])
        begin
          rand_data(n, q);
          spi_write(addr, q);
        end
        else
          spi_read(addr, n);
      end
      assert (refreshes - ref_start >= 3)
      else
      begin
        value_errors++;
        $display("only %0d refreshes seen during traffic", refreshes - ref_start);
      end

      $display("value errors %0d, sdram protocol errors %0d", value_errors, model_errors);
      if (value_errors == 0 && model_errors == 0)
        $display("TESTBENCH PASSED");
      else
        $display("TESTBENCH FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/spi_sdram_pkg.sv
rtl/spi_bus_slave.sv
rtl/byte_word_bridge.sv
rtl/sdram_ctrl.sv
rtl/spi_sdram_top.sv
bench/sdram_model.sv
bench/tb_spi_sdram.sv

// ==== rtl/byte_word_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_word_bridge
  import spi_sdram_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  spi_bus_t    bus,
  output logic [7:0]  byte_rdata,
  output mem_req_t    req,
  input  logic        busy,
  input  logic [15:0] rdata,
  input  logic        rd_valid,
  output logic [7:0]  ctrl_reg
);

  logic [7:0]                region;
  logic                      in_sdram;
  logic                      in_ctrl;
  logic [7:0]                stage [2];   // [0] even byte = upper half
  logic                      pend_we;     // one-deep pending slot
  logic                      pend_re;
  logic [WORD_ADDR_BITS-1:0] pend_addr;
  logic                      issue;
  logic                      rd_sdram;    // region of the last rd
  logic                      rd_ctrl;
  logic                      rd_sel;      // byte lane of the last rd
  logic [15:0]               rword;

  assign region   = bus.addr[31:24];
  assign in_sdram = (region == REGION_SDRAM);
  assign in_ctrl  = (region == REGION_CTRL);
  assign issue    = (pend_we | pend_re) & ~busy;

  // slot goes out as soon as the controller is free
  always_comb
  begin
    req.we    = pend_we & ~busy;
    req.re    = pend_re & ~busy;
    req.waddr = pend_addr;
    req.wdata = {stage[0], stage[1]};
  end

  always_ff @(posedge clk)
  begin
    if (bus.wr && in_sdram)
      stage[bus.addr[0]] <= bus.wdata;
    if (rd_valid)
      rword <= rdata;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ctrl_reg  <= 8'd0;
      pend_we   <= 1'b0;
      pend_re   <= 1'b0;
      pend_addr <= '0;
      rd_sdram  <= 1'b0;
      rd_ctrl   <= 1'b0;
      rd_sel    <= 1'b0;
    end
    else
    begin
      if (issue)
      begin
        pend_we <= 1'b0;
        pend_re <= 1'b0;
      end
      if (bus.wr)
      begin
        if (in_ctrl)
          ctrl_reg <= bus.wdata;
        if (in_sdram && bus.addr[0])  // odd byte commits the word
        begin
          pend_we   <= 1'b1;
          pend_addr <= bus.addr[WORD_ADDR_BITS:1];
        end
      end
      if (bus.rd)
      begin
        rd_sdram <= in_sdram;
        rd_ctrl  <= in_ctrl;
        rd_sel   <= bus.addr[0];
        if (in_sdram)
        begin
          pend_re   <= 1'b1;
          pend_addr <= bus.addr[WORD_ADDR_BITS:1];
        end
      end
    end
  end

  // other regions read back as zero
  assign byte_rdata = rd_sdram ? (rd_sel ? rword[7:0] : rword[15:8]) :
                      rd_ctrl  ? ctrl_reg : 8'd0;

endmodule

`default_nettype wire

// ==== rtl/sdram_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl
  import spi_sdram_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  mem_req_t             req,
  output logic                 busy,
  output logic [15:0]          rdata,
  output logic                 rd_valid,
  output logic                 ready,
  output logic                 sdram_cke,
  output logic                 sdram_csn,
  output logic                 sdram_rasn,
  output logic                 sdram_casn,
  output logic                 sdram_wen,
  output logic [ROW_BITS-1:0]  sdram_a,
  output logic [BANK_BITS-1:0] sdram_ba,
  output logic [1:0]           sdram_dqm,
  inout  wire  [15:0]          sdram_dq
);

  typedef enum logic [3:0] {
    S_INIT_WAIT,
    S_INIT_PRECHARGE,
    S_INIT_REFRESH,
    S_INIT_MODE,
    S_IDLE,
    S_ACTIVATE,
    S_RW,
    S_PRECHARGE_WAIT,
    S_REFRESH,
    S_READ_WAIT
  } state_t;

  state_t               state;
  sdram_cmd_t           cmd;        // registered onto the command pins
  logic [WAIT_BITS-1:0] wait_cnt;   // shared by every state
  logic                 wait_done;
  logic [1:0]           init_refs;
  logic [REF_BITS-1:0]  ref_cnt;
  logic                 ref_due;
  logic                 ref_issue;
  mem_req_t             op;         // accepted request
  logic [15:0]          dq_out;
  logic                 dq_oe;
  logic [15:0]          dq_in;      // input register on the dq pins

  function automatic logic [ROW_BITS-1:0] row_of(input logic [WORD_ADDR_BITS-1:0] wa);
    return {1'b0, wa[WORD_ADDR_BITS-1:COL_BITS+BANK_BITS]};
  endfunction

  function automatic logic [BANK_BITS-1:0] bank_of(input logic [WORD_ADDR_BITS-1:0] wa);
    return wa[COL_BITS +: BANK_BITS];
  endfunction

  assign {sdram_csn, sdram_rasn, sdram_casn, sdram_wen} = cmd;
  assign sdram_dqm = 2'b00;                  // full words only
  assign sdram_dq  = dq_oe ? dq_out : 16'hzzzz;
  assign wait_done = (wait_cnt == '0);
  assign ref_issue = (state == S_IDLE) && ref_due;

  always_ff @(posedge clk)
    dq_in <= sdram_dq;

  // refresh interval timer, starts once init is through
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ref_cnt <= '0;
      ref_due <= 1'b0;
    end
    else if (!ready || ref_issue)
    begin
      ref_cnt <= '0;
      ref_due <= 1'b0;
    end
    else if (ref_cnt == REF_BITS'(REFRESH_INTERVAL - 1))
      ref_due <= 1'b1;   // held until idle
    else
      ref_cnt <= ref_cnt + 1'b1;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state     <= S_INIT_WAIT;
      cmd       <= NOP;
      wait_cnt  <= WAIT_BITS'(INIT_WAIT_CYCLES - 1);
      init_refs <= 2'd0;
      busy      <= 1'b1;   // nothing accepted during init
      ready     <= 1'b0;
      rd_valid  <= 1'b0;
      rdata     <= 16'd0;
      sdram_cke <= 1'b0;
      sdram_a   <= '0;
      sdram_ba  <= '0;
      dq_out    <= 16'd0;
      dq_oe     <= 1'b0;
      op        <= '0;
    end
    else
    begin
      cmd      <= NOP;
      dq_oe    <= 1'b0;
      rd_valid <= 1'b0;
      if (!wait_done)
        wait_cnt <= wait_cnt - 1'b1;
      case (state)
        S_INIT_WAIT:
          if (wait_done)
          begin
            sdram_cke <= 1'b1;
            wait_cnt  <= WAIT_BITS'(1);  // a few NOPs with cke high
            state     <= S_INIT_PRECHARGE;
          end
        S_INIT_PRECHARGE:
          if (wait_done)
          begin
            cmd      <= PRECHARGE;
            sdram_a  <= AUTO_PRECHARGE;  // a10 high, all banks
            wait_cnt <= WAIT_BITS'(T_RP - 1);
            state    <= S_INIT_REFRESH;
          end
        S_INIT_REFRESH:
          if (wait_done)
          begin
            if (init_refs == 2'd2)
            begin
              cmd      <= LOAD_MODE;
              sdram_a  <= MODE_REG;
              sdram_ba <= '0;
              wait_cnt <= WAIT_BITS'(T_MRD - 1);
              state    <= S_INIT_MODE;
            end
            else
            begin
              cmd       <= REFRESH;
              init_refs <= init_refs + 2'd1;
              wait_cnt  <= WAIT_BITS'(T_RFC - 1);
            end
          end
        S_INIT_MODE:
          if (wait_done)
          begin
            ready <= 1'b1;
            busy  <= 1'b0;
            state <= S_IDLE;
          end
        S_IDLE:
          if (ref_due)
          begin
            // refresh wins, request (if any) parked in op
            cmd      <= REFRESH;
            op       <= req;
            busy     <= 1'b1;
            wait_cnt <= WAIT_BITS'(T_RFC - 1);
            state    <= S_REFRESH;
          end
          else if (req.we || req.re)
          begin
            cmd      <= ACTIVE;
            sdram_a  <= row_of(req.waddr);
            sdram_ba <= bank_of(req.waddr);
            op       <= req;
            busy     <= 1'b1;
            wait_cnt <= WAIT_BITS'(T_RCD - 2);
            state    <= S_ACTIVATE;
          end
        S_REFRESH:
          if (wait_done)
          begin
            if (op.we || op.re)
            begin
              cmd      <= ACTIVE;
              sdram_a  <= row_of(op.waddr);
              sdram_ba <= bank_of(op.waddr);
              wait_cnt <= WAIT_BITS'(T_RCD - 2);
              state    <= S_ACTIVATE;
            end
            else
            begin
              busy  <= 1'b0;
              state <= S_IDLE;
            end
          end
        S_ACTIVATE:
          if (wait_done)
            state <= S_RW;  // trcd met on the next edge
        S_RW:
        begin
          sdram_a  <= ROW_BITS'(op.waddr[COL_BITS-1:0]) | AUTO_PRECHARGE;
          sdram_ba <= bank_of(op.waddr);
          if (op.we)
          begin
            cmd      <= WRITE;
            dq_oe    <= 1'b1;  // dq driven only in the WRITE cycle
            dq_out   <= op.wdata;
            wait_cnt <= WAIT_BITS'(T_RP);  // write recovery then precharge
            state    <= S_PRECHARGE_WAIT;
          end
          else
          begin
            cmd      <= READ;
            wait_cnt <= WAIT_BITS'(CAS_LATENCY + 1);  // cl plus the dq_in stage
            state    <= S_READ_WAIT;
          end
        end
        S_PRECHARGE_WAIT:
          if (wait_done)
          begin
            busy  <= 1'b0;
            state <= S_IDLE;
          end
        S_READ_WAIT:
          if (wait_done)
          begin
            rdata    <= dq_in;
            rd_valid <= 1'b1;
            busy     <= 1'b0;
            state    <= S_IDLE;
          end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/spi_bus_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_bus_slave
  import spi_sdram_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       csn,
  input  logic       sclk,
  input  logic       mosi,
  output logic       miso,
  output spi_bus_t   bus,
  input  logic [7:0] rdata
);

  typedef enum logic [1:0] {
    S_CMD,
    S_ADDR,
    S_DUMMY,
    S_DATA
  } state_t;

  logic [1:0] csn_s;
  logic [2:0] sclk_s;    // [2] is the delayed copy for edge detect
  logic [1:0] mosi_s;
  logic       active;
  logic       sclk_rise;
  logic       sclk_fall;
  logic       byte_done;
  logic [7:0] rx_byte;

  state_t     state;
  logic [2:0] bit_cnt;
  logic [1:0] addr_cnt;  // address bytes seen
  logic [6:0] shift_in;
  logic [7:0] shift_out;
  logic       is_rd;
  logic       is_wr;

  // sclk is just a sampled pin here, never a clock
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      csn_s  <= 2'b11;
      sclk_s <= 3'b000;
      mosi_s <= 2'b00;
    end
    else
    begin
      csn_s  <= {csn_s[0], csn};
      sclk_s <= {sclk_s[1:0], sclk};
      mosi_s <= {mosi_s[0], mosi};
    end
  end

  assign active    = ~csn_s[1];
  assign sclk_rise = sclk_s[1] & ~sclk_s[2];
  assign sclk_fall = ~sclk_s[1] & sclk_s[2];
  assign rx_byte   = {shift_in, mosi_s[1]};  // msb first
  assign byte_done = active & sclk_rise & (bit_cnt == 3'd7);

  // frame decode and bus strobes
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state    <= S_CMD;
      bit_cnt  <= 3'd0;
      addr_cnt <= 2'd0;
      shift_in <= 7'd0;
      is_rd    <= 1'b0;
      is_wr    <= 1'b0;
      bus      <= '0;
    end
    else
    begin
      bus.rd <= 1'b0;
      bus.wr <= 1'b0;
      if (bus.wr)
        bus.addr <= bus.addr + 32'd1;  // step after the write strobe
      if (!active)
      begin
        // csn high aborts whatever frame was running
        state    <= S_CMD;
        bit_cnt  <= 3'd0;
        addr_cnt <= 2'd0;
        is_rd    <= 1'b0;
        is_wr    <= 1'b0;
      end
      else
      begin
        if (sclk_rise)
        begin
          shift_in <= rx_byte[6:0];
          bit_cnt  <= bit_cnt + 3'd1;
        end
        if (byte_done)
        begin
          case (state)
            S_CMD:
            begin
              is_rd    <= (rx_byte == SPI_CMD_READ);
              is_wr    <= (rx_byte == SPI_CMD_WRITE);  // unknown cmd does nothing
              addr_cnt <= 2'd0;
              state    <= S_ADDR;
            end
            S_ADDR:
            begin
              bus.addr <= {bus.addr[23:0], rx_byte};
              addr_cnt <= addr_cnt + 2'd1;
              if (addr_cnt == 2'd3)
              begin
                bus.rd <= is_rd;  // first prefetch, for the start addr
                state  <= is_rd ? S_DUMMY : S_DATA;
              end
            end
            S_DUMMY,
            S_DATA:
            begin
              if (is_wr)
              begin
                bus.wdata <= rx_byte;
                bus.wr    <= 1'b1;
              end
              if (is_rd)
              begin
                bus.addr <= bus.addr + 32'd1;  // fetch the byte after the one going out
                bus.rd   <= 1'b1;
              end
              state <= S_DATA;
            end
            default: state <= S_CMD;
          endcase
        end
      end
    end
  end

  // miso shifts on falling sclk, reloaded at each byte boundary of a read
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      miso      <= 1'b0;
      shift_out <= 8'd0;
    end
    else if (!active)
    begin
      miso      <= 1'b0;
      shift_out <= 8'd0;
    end
    else if (byte_done && is_rd && (state == S_DUMMY || state == S_DATA))
      shift_out <= rdata;  // prefetched one byte time earlier
    else if (sclk_fall)
    begin
      miso      <= shift_out[7];
      shift_out <= {shift_out[6:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

// ==== rtl/spi_sdram_pkg.sv ====
`default_nettype none

package spi_sdram_pkg;

  // sdram geometry, 16-bit words, word addr = {row, bank, col}
  localparam int ROW_BITS       = 13;
  localparam int COL_BITS       = 9;
  localparam int BANK_BITS      = 2;
  localparam int WORD_ADDR_BITS = 23;   // row msb stays zero

  // timing in clk cycles, 100 MHz assumed
  localparam int INIT_WAIT_CYCLES = 20000;   // ~200 us power-up
  localparam int T_RCD            = 2;
  localparam int T_RP             = 2;
  localparam int T_RFC            = 7;
  localparam int T_MRD            = 2;
  localparam int CAS_LATENCY      = 2;
  localparam int REFRESH_INTERVAL = 780;     // 8192 rows in 64 ms

  localparam int WAIT_BITS = $clog2(INIT_WAIT_CYCLES);
  localparam int REF_BITS  = $clog2(REFRESH_INTERVAL);

  // burst length 1, sequential, CL2, burst write off
  localparam logic [ROW_BITS-1:0] MODE_REG       = 13'h020;
  localparam logic [ROW_BITS-1:0] AUTO_PRECHARGE = 13'h0400;  // a10

  // spi frame command byte and address regions (top addr byte)
  localparam logic [7:0] SPI_CMD_WRITE = 8'h00;
  localparam logic [7:0] SPI_CMD_READ  = 8'h01;
  localparam logic [7:0] REGION_SDRAM  = 8'h00;
  localparam logic [7:0] REGION_CTRL   = 8'hFF;

  // {csn, rasn, casn, wen}
  typedef enum logic [3:0] {
    LOAD_MODE = 4'b0000,
    REFRESH   = 4'b0001,
    PRECHARGE = 4'b0010,
    ACTIVE    = 4'b0011,
    WRITE     = 4'b0100,
    READ      = 4'b0101,
    NOP       = 4'b0111
  } sdram_cmd_t;

  typedef struct packed {
    logic        rd;      // byte read strobe
    logic        wr;      // byte write strobe
    logic [31:0] addr;
    logic [7:0]  wdata;
  } spi_bus_t;

  typedef struct packed {
    logic                      we;   // word write strobe
    logic                      re;   // word read strobe
    logic [WORD_ADDR_BITS-1:0] waddr;
    logic [15:0]               wdata;
  } mem_req_t;

endpackage

`default_nettype wire

// ==== rtl/spi_sdram_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_sdram_top
  import spi_sdram_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        spi_csn,
  input  logic        spi_sclk,   // oversampled, not a clock
  input  logic        spi_mosi,
  output logic        spi_miso,
  output logic        sdram_cke,
  output logic        sdram_csn,
  output logic        sdram_rasn,
  output logic        sdram_casn,
  output logic        sdram_wen,
  output logic [12:0] sdram_a,
  output logic [1:0]  sdram_ba,
  output logic [1:0]  sdram_dqm,
  inout  wire  [15:0] sdram_dq,
  output logic [7:0]  ctrl_reg,
  output logic        sdram_ready
);

  spi_bus_t    bus;         // byte strobes from the spi side
  mem_req_t    req;         // word requests to the controller
  logic [7:0]  byte_rdata;
  logic        busy;
  logic [15:0] rdata;
  logic        rd_valid;

  spi_bus_slave i_spi_bus_slave (
    .clk    (clk),
    .arst_n (arst_n),
    .csn    (spi_csn),
    .sclk   (spi_sclk),
    .mosi   (spi_mosi),
    .miso   (spi_miso),
    .bus    (bus),
    .rdata  (byte_rdata)
  );

  byte_word_bridge i_byte_word_bridge (
    .clk        (clk),
    .arst_n     (arst_n),
    .bus        (bus),
    .byte_rdata (byte_rdata),
    .req        (req),
    .busy       (busy),
    .rdata      (rdata),
    .rd_valid   (rd_valid),
    .ctrl_reg   (ctrl_reg)
  );

  sdram_ctrl i_sdram_ctrl (
    .clk        (clk),
    .arst_n     (arst_n),
    .req        (req),
    .busy       (busy),
    .rdata      (rdata),
    .rd_valid   (rd_valid),
    .ready      (sdram_ready),
    .sdram_cke  (sdram_cke),
    .sdram_csn  (sdram_csn),
    .sdram_rasn (sdram_rasn),
    .sdram_casn (sdram_casn),
    .sdram_wen  (sdram_wen),
    .sdram_a    (sdram_a),
    .sdram_ba   (sdram_ba),
    .sdram_dqm  (sdram_dqm),
    .sdram_dq   (sdram_dq)
  );

endmodule

`default_nettype wire
